//--- source/mmu_pkg.sv
package mmu_pkg;

	// ==============================
	// Field widths
	// ==============================

	// Word address into the shared table memory
	localparam int MEM_AW = 12;
	// One index field selects a word inside one table
	localparam int TABLE_IDX_W = 10;
	// Table number sits above the index in a memory address
	localparam int TABLE_NUM_W = MEM_AW - TABLE_IDX_W;
	localparam int PAGE_OFS_W = 12;
	// Virtual page number is both table indices together
	localparam int VPN_W = 2 * TABLE_IDX_W;
	localparam int PPN_W = 20;
	localparam int ASID_W = 8;

	// ==============================
	// Addresses and table entries
	// ==============================

	// Level-1 index on top, then level-0 index, then page offset
	typedef struct packed {
		logic [TABLE_IDX_W-1:0] l1_idx;
		logic [TABLE_IDX_W-1:0] l0_idx;
		logic [PAGE_OFS_W-1:0]  offset;
	} vaddr_t;

	typedef struct packed {
		logic [PPN_W-1:0]      ppn;
		logic [PAGE_OFS_W-1:0] offset;
	} paddr_t;

	typedef logic [ASID_W-1:0] asid_t;

	// One 32-bit table word
	// At level 1 the low ppn bits name the next table
	typedef struct packed {
		logic             v;
		logic [PPN_W-1:0] ppn;
		logic [10:0]      spare;
	} pte_t;

	// ==============================
	// Memory and lookup transfers
	// ==============================

	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_op_e;

	typedef struct packed {
		mem_op_e           op;
		logic [MEM_AW-1:0] addr;
		logic [31:0]       wdata;
	} mem_req_t;

	typedef struct packed {
		vaddr_t vaddr;
		asid_t  asid;
	} xlate_req_t;

	// Paddr reads as zero on a fault
	typedef struct packed {
		logic   fault;
		paddr_t paddr;
	} xlate_resp_t;

	// Refill entry from the walker, full vpn
	// The TLB keeps only the bits above its own index
	typedef struct packed {
		logic             valid;
		asid_t            asid;
		logic [VPN_W-1:0] vpn;
		logic [PPN_W-1:0] ppn;
	} tlb_entry_t;

	typedef enum logic [2:0] {
		W_IDLE,
		W_L1_REQ,
		W_L1_WAIT,
		W_L0_REQ,
		W_L0_WAIT,
		W_DONE
	} walk_state_e;

endpackage

//--- source/ptable_mem.sv
module ptable_mem
	import mmu_pkg::*;
#(
	parameter int MEM_WORDS = 4096
) (
	input  logic        clk,
	input  logic        mem_en_i,
	input  mem_req_t    mem_i,
	output logic [31:0] rdata_o
);

	localparam int AW = $clog2(MEM_WORDS);

	// Table words, content undefined until written
	logic [31:0]   mem_q [MEM_WORDS];
	logic [AW-1:0] addr;

	assign addr = mem_i.addr[AW-1:0];

	// Registered read, write lands on the enable edge
	always_ff @(posedge clk) begin
		if (mem_en_i) begin
			if (mem_i.op == MEM_WRITE)
				mem_q[addr] <= mem_i.wdata;
			else
				rdata_o <= mem_q[addr];
		end
	end

	// Table numbers beyond the array would alias
	a_addr_in_range: assert property (@(posedge clk)
		mem_en_i |-> (mem_i.addr < MEM_WORDS));

endmodule

//--- source/mem_arbiter.sv
module mem_arbiter
	import mmu_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	// Host peer
	input  logic        host_req_i,
	input  mem_req_t    host_i,
	output logic        host_ack_o,
	output logic [31:0] host_rdata_o,
	// Walker peer
	input  logic        walk_req_i,
	input  mem_req_t    walk_i,
	output logic        walk_ack_o,
	output logic [31:0] walk_rdata_o,
	// Memory side
	output logic        mem_en_o,
	output mem_req_t    mem_o,
	input  logic [31:0] mem_rdata_i
);

	typedef enum logic [1:0] {A_IDLE, A_MEM, A_ACK} arb_state_e;

	arb_state_e state_q;
	// Bit 0 host, bit 1 walker
	logic [1:0] grant_q;
	logic [1:0] ack_q;
	logic [1:0] req;
	// Set when the walker won last
	logic       last_q;
	logic       mem_en_q;
	mem_req_t   mem_q;
	logic       pick_walk;

	assign req = {walk_req_i, host_req_i};
	// Walker wins alone, or on a tie after a host turn
	assign pick_walk = walk_req_i && (!host_req_i || !last_q);

	assign mem_en_o   = mem_en_q;
	assign mem_o      = mem_q;
	assign host_ack_o = ack_q[0];
	assign walk_ack_o = ack_q[1];
	// Memory output holds until the next enable, which waits for the release
	assign host_rdata_o = mem_rdata_i;
	assign walk_rdata_o = mem_rdata_i;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q  <= A_IDLE;
			grant_q  <= 2'b00;
			ack_q    <= 2'b00;
			last_q   <= 1'b0;
			mem_en_q <= 1'b0;
		end else begin
			case (state_q)
				// Grant and issue on one edge
				A_IDLE: begin
					if (|req) begin
						grant_q  <= pick_walk ? 2'b10 : 2'b01;
						last_q   <= pick_walk;
						mem_en_q <= 1'b1;
						state_q  <= A_MEM;
					end
				end
				// Memory cycle, data registered on this edge
				A_MEM: begin
					mem_en_q <= 1'b0;
					ack_q    <= grant_q;
					state_q  <= A_ACK;
				end
				// Hold until the winner lets go
				A_ACK: begin
					if (!(|(req & grant_q))) begin
						ack_q   <= 2'b00;
						grant_q <= 2'b00;
						state_q <= A_IDLE;
					end
				end
				default: state_q <= A_IDLE;
			endcase
		end
	end

	// Winner's request goes out with the grant
	always_ff @(posedge clk) begin
		if (state_q == A_IDLE)
			mem_q <= pick_walk ? walk_i : host_i;
	end

	a_one_ack: assert property (@(posedge clk) disable iff (rst)
		!(host_ack_o && walk_ack_o));

endmodule

//--- source/ptable_walker.sv
module ptable_walker
	import mmu_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic [TABLE_NUM_W-1:0] ptbr_i,
	// Walk port from the TLB
	input  logic                   walk_req_i,
	input  xlate_req_t             walk_i,
	output logic                   walk_ack_o,
	output xlate_resp_t            walk_resp_o,
	// Memory peer on the arbiter
	output logic                   mem_req_o,
	output mem_req_t               mem_o,
	input  logic                   mem_ack_i,
	input  logic [31:0]            mem_rdata_i,
	// TLB refill
	output logic                   tlb_wr_o,
	output tlb_entry_t             tlb_wr_entry_o
);

	walk_state_e       state_q;
	logic              mem_req_q;
	logic              ack_q;
	logic              tlb_wr_q;
	xlate_req_t        xreq_q;
	pte_t              pte_q;
	logic [MEM_AW-1:0] addr_q;
	xlate_resp_t       resp_q;

	// Walker only ever reads tables
	assign mem_o       = '{op: MEM_READ, addr: addr_q, wdata: 32'd0};
	assign mem_req_o   = mem_req_q;
	assign walk_ack_o  = ack_q;
	assign walk_resp_o = resp_q;
	assign tlb_wr_o    = tlb_wr_q;

	// Refill entry from the held request and the level-0 word
	assign tlb_wr_entry_o = '{
		valid: pte_q.v,
		asid:  xreq_q.asid,
		vpn:   {xreq_q.vaddr.l1_idx, xreq_q.vaddr.l0_idx},
		ppn:   pte_q.ppn
	};

	// ==============================
	// Walk state machine
	// ==============================

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q   <= W_IDLE;
			mem_req_q <= 1'b0;
			ack_q     <= 1'b0;
			tlb_wr_q  <= 1'b0;
		end else begin
			// Refill strobe is a single cycle
			tlb_wr_q <= 1'b0;
			case (state_q)
				W_IDLE: begin
					if (walk_req_i) begin
						mem_req_q <= 1'b1;
						state_q   <= W_L1_REQ;
					end
				end
				W_L1_REQ: begin
					if (mem_ack_i) begin
						mem_req_q <= 1'b0;
						state_q   <= W_L1_WAIT;
					end
				end
				// Level-1 word held, wait for the arbiter release
				W_L1_WAIT: begin
					if (!mem_ack_i) begin
						if (pte_q.v) begin
							mem_req_q <= 1'b1;
							state_q   <= W_L0_REQ;
						end else begin
							ack_q   <= 1'b1;
							state_q <= W_DONE;
						end
					end
				end
				W_L0_REQ: begin
					if (mem_ack_i) begin
						mem_req_q <= 1'b0;
						state_q   <= W_L0_WAIT;
					end
				end
				// Refill lands on the same edge the TLB sees the ack
				W_L0_WAIT: begin
					if (!mem_ack_i) begin
						tlb_wr_q <= pte_q.v;
						ack_q    <= 1'b1;
						state_q  <= W_DONE;
					end
				end
				W_DONE: begin
					if (!walk_req_i) begin
						ack_q   <= 1'b0;
						state_q <= W_IDLE;
					end
				end
				default: state_q <= W_IDLE;
			endcase
		end
	end

	// Address, entry and response payload
	always_ff @(posedge clk) begin
		case (state_q)
			W_IDLE: begin
				xreq_q <= walk_i;
				// Level-1 word sits in the base table
				addr_q <= {ptbr_i, walk_i.vaddr.l1_idx};
			end
			W_L1_REQ, W_L0_REQ: begin
				if (mem_ack_i)
					pte_q <= pte_t'(mem_rdata_i);
			end
			W_L1_WAIT: begin
				// Next table named by the low ppn bits
				addr_q       <= {pte_q.ppn[TABLE_NUM_W-1:0], xreq_q.vaddr.l0_idx};
				resp_q.fault <= !pte_q.v;
				resp_q.paddr <= '0;
			end
			W_L0_WAIT: begin
				resp_q.fault <= !pte_q.v;
				resp_q.paddr <= pte_q.v ? {pte_q.ppn, xreq_q.vaddr.offset} : '0;
			end
			default: ;
		endcase
	end

	// Request held steady until the arbiter answers
	a_mem_stable: assert property (@(posedge clk) disable iff (rst)
		(mem_req_o && !mem_ack_i) |=> $stable(mem_o));

endmodule

//--- source/tlb.sv
module tlb
	import mmu_pkg::*;
#(
	parameter int TLB_ENTRIES = 16
) (
	input  logic        clk,
	input  logic        rst,
	// Lookup port
	input  logic        xlate_req_i,
	input  xlate_req_t  xlate_i,
	output logic        xlate_ack_o,
	output xlate_resp_t resp_o,
	input  logic        flush_i,
	// Miss hand-off to the walker
	output logic        walk_req_o,
	output xlate_req_t  walk_o,
	input  logic        walk_ack_i,
	input  xlate_resp_t walk_resp_i,
	// Refill
	input  logic        tlb_wr_i,
	input  tlb_entry_t  tlb_wr_entry_i
);

	localparam int IDX_W = $clog2(TLB_ENTRIES);
	localparam int TAG_W = VPN_W - IDX_W;

	typedef enum logic [2:0] {T_IDLE, T_LOOKUP, T_WALK, T_WALK_REL, T_RESP} tlb_state_e;

	tlb_state_e             state_q;
	logic [TLB_ENTRIES-1:0] valid_q;
	logic                   ack_q;
	logic                   walk_req_q;
	xlate_resp_t            resp_q;
	xlate_req_t             walk_q;

	// Entry arrays, indexed by the low vpn bits
	logic [TAG_W-1:0] tag_mem  [TLB_ENTRIES];
	asid_t            asid_mem [TLB_ENTRIES];
	logic [PPN_W-1:0] ppn_mem  [TLB_ENTRIES];

	// Registered read of the indexed entry
	logic             rd_valid_q;
	logic [TAG_W-1:0] rd_tag_q;
	asid_t            rd_asid_q;
	logic [PPN_W-1:0] rd_ppn_q;

	logic [VPN_W-1:0] req_vpn;
	logic [IDX_W-1:0] req_idx;
	logic [IDX_W-1:0] wr_idx;
	logic             hit;

	assign req_vpn = {xlate_i.vaddr.l1_idx, xlate_i.vaddr.l0_idx};
	assign req_idx = req_vpn[IDX_W-1:0];
	assign wr_idx  = tlb_wr_entry_i.vpn[IDX_W-1:0];
	// Tag and ASID must both match
	assign hit = rd_valid_q && (rd_tag_q == req_vpn[VPN_W-1:IDX_W]) && (rd_asid_q == xlate_i.asid);

	assign xlate_ack_o = ack_q;
	assign resp_o      = resp_q;
	assign walk_req_o  = walk_req_q;
	assign walk_o      = walk_q;

	// Refill write and tag read, every cycle
	always_ff @(posedge clk) begin
		if (tlb_wr_i) begin
			tag_mem[wr_idx]  <= tlb_wr_entry_i.vpn[VPN_W-1:IDX_W];
			asid_mem[wr_idx] <= tlb_wr_entry_i.asid;
			ppn_mem[wr_idx]  <= tlb_wr_entry_i.ppn;
		end
		rd_valid_q <= valid_q[req_idx];
		rd_tag_q   <= tag_mem[req_idx];
		rd_asid_q  <= asid_mem[req_idx];
		rd_ppn_q   <= ppn_mem[req_idx];
	end

	// ==============================
	// Lookup and miss sequencing
	// ==============================

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q    <= T_IDLE;
			valid_q    <= '0;
			ack_q      <= 1'b0;
			walk_req_q <= 1'b0;
		end else begin
			if (tlb_wr_i)
				valid_q[wr_idx] <= tlb_wr_entry_i.valid;
			case (state_q)
				T_IDLE: begin
					// Flush wins over a lookup starting on the same edge
					if (flush_i)
						valid_q <= '0;
					else if (xlate_req_i)
						state_q <= T_LOOKUP;
				end
				T_LOOKUP: begin
					if (hit) begin
						ack_q   <= 1'b1;
						state_q <= T_RESP;
					end else begin
						walk_req_q <= 1'b1;
						state_q    <= T_WALK;
					end
				end
				T_WALK: begin
					if (walk_ack_i) begin
						walk_req_q <= 1'b0;
						state_q    <= T_WALK_REL;
					end
				end
				// Walker drops its ack before the requester sees ours
				T_WALK_REL: begin
					if (!walk_ack_i) begin
						ack_q   <= 1'b1;
						state_q <= T_RESP;
					end
				end
				T_RESP: begin
					if (!xlate_req_i) begin
						ack_q   <= 1'b0;
						state_q <= T_IDLE;
					end
				end
				default: state_q <= T_IDLE;
			endcase
		end
	end

	// Response and hand-off payload
	always_ff @(posedge clk) begin
		if (state_q == T_LOOKUP) begin
			resp_q.fault <= 1'b0;
			resp_q.paddr <= {rd_ppn_q, xlate_i.vaddr.offset};
			walk_q       <= xlate_i;
		end else if (state_q == T_WALK && walk_ack_i) begin
			resp_q <= walk_resp_i;
		end
	end

	// Each ack answers a request that was still up one edge before
	a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
		xlate_ack_o |-> $past(xlate_req_i));

	// Flush pulses only land between lookups
	a_flush_idle: assert property (@(posedge clk) disable iff (rst)
		flush_i |-> (state_q == T_IDLE));

endmodule

//--- source/mmu_top.sv
module mmu_top
	import mmu_pkg::*;
#(
	parameter int TLB_ENTRIES = 16,
	parameter int MEM_WORDS   = 4096
) (
	input  logic                   clk,
	input  logic                   rst,
	// Translation port
	input  logic                   xlate_req_i,
	input  xlate_req_t             xlate_i,
	output logic                   xlate_ack_o,
	output xlate_resp_t            resp_o,
	input  logic                   flush_i,
	// Base table number
	input  logic [TABLE_NUM_W-1:0] ptbr_i,
	// Host port onto the table memory
	input  logic                   host_req_i,
	input  mem_req_t               host_i,
	output logic                   host_ack_o,
	output logic [31:0]            host_rdata_o
);

	// TLB to walker
	logic        walk_req;
	xlate_req_t  walk_xreq;
	logic        walk_ack;
	xlate_resp_t walk_resp;
	logic        tlb_wr;
	tlb_entry_t  tlb_wr_entry;

	// Walker to arbiter
	logic        wmem_req;
	mem_req_t    wmem;
	logic        wmem_ack;
	logic [31:0] wmem_rdata;

	// Arbiter to memory
	logic        mem_en;
	mem_req_t    mem_req;
	logic [31:0] mem_rdata;

	tlb #(
		.TLB_ENTRIES(TLB_ENTRIES)
	) i_tlb (
		.clk(clk), .rst(rst),
		.xlate_req_i(xlate_req_i), .xlate_i(xlate_i),
		.xlate_ack_o(xlate_ack_o), .resp_o(resp_o),
		.flush_i(flush_i),
		.walk_req_o(walk_req), .walk_o(walk_xreq),
		.walk_ack_i(walk_ack), .walk_resp_i(walk_resp),
		.tlb_wr_i(tlb_wr), .tlb_wr_entry_i(tlb_wr_entry)
	);

	ptable_walker i_walker (
		.clk(clk), .rst(rst), .ptbr_i(ptbr_i),
		.walk_req_i(walk_req), .walk_i(walk_xreq),
		.walk_ack_o(walk_ack), .walk_resp_o(walk_resp),
		.mem_req_o(wmem_req), .mem_o(wmem),
		.mem_ack_i(wmem_ack), .mem_rdata_i(wmem_rdata),
		.tlb_wr_o(tlb_wr), .tlb_wr_entry_o(tlb_wr_entry)
	);

	mem_arbiter i_arbiter (
		.clk(clk), .rst(rst),
		.host_req_i(host_req_i), .host_i(host_i),
		.host_ack_o(host_ack_o), .host_rdata_o(host_rdata_o),
		.walk_req_i(wmem_req), .walk_i(wmem),
		.walk_ack_o(wmem_ack), .walk_rdata_o(wmem_rdata),
		.mem_en_o(mem_en), .mem_o(mem_req), .mem_rdata_i(mem_rdata)
	);

	ptable_mem #(
		.MEM_WORDS(MEM_WORDS)
	) i_mem (
		.clk(clk), .mem_en_i(mem_en), .mem_i(mem_req), .rdata_o(mem_rdata)
	);

endmodule

//--- tb/tb_clock.sv
module tb_clock #(
	parameter int HALF_PERIOD  = 5,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_o,
	output logic rst_o
);

	// Free-running clock, 10 units per period
	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	// Reset released just after an edge
	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1;
		rst_o = 1'b0;
	end

endmodule

//--- tb/mmu_checker.sv
module mmu_checker
	import mmu_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        xlate_ack_i,
	input  xlate_resp_t resp_i,
	input  logic        host_ack_i,
	input  mem_req_t    host_i,
	input  logic [31:0] host_rdata_i
);

	// Expected values, oldest first
	xlate_resp_t xlate_exp_q [$];
	logic [31:0] host_exp_q  [$];

	// Compare counts, written by the monitor only
	int cmp_checks  = 0;
	int cmp_errors  = 0;
	// Errors found by the stimulus side
	int tb_errors   = 0;
	// Counts at the end of the previous test
	int mark_checks = 0;
	int mark_errors = 0;

	logic xlate_ack_q = 1'b0;
	logic host_ack_q  = 1'b0;

	task automatic expect_xlate(input xlate_resp_t r);
		xlate_exp_q.push_back(r);
	endtask

	task automatic expect_host(input logic [31:0] d);
		host_exp_q.push_back(d);
	endtask

	task automatic log_error();
		tb_errors++;
	endtask

	function automatic int error_count();
		return cmp_errors + tb_errors;
	endfunction

	// ==============================
	// Response monitor
	// ==============================

	// Mid-cycle sampling, outputs settled
	always @(negedge clk) begin
		xlate_ack_q <= xlate_ack_i;
		host_ack_q  <= host_ack_i;
		if (!rst && xlate_ack_i && !xlate_ack_q)
			compare_xlate();
		// Host writes return no data
		if (!rst && host_ack_i && !host_ack_q && host_i.op == MEM_READ)
			compare_host();
	end

	task automatic compare_xlate();
		xlate_resp_t want;
		if (xlate_exp_q.size() == 0) begin
			$display("Error at time %0t: translation answered with no request outstanding", $time);
			cmp_errors++;
		end else begin
			want = xlate_exp_q.pop_front();
			cmp_checks++;
			if (resp_i !== want) begin
				$display("Mismatch at time %0t: resp_o expected fault=%0b paddr=%h, actual fault=%0b paddr=%h",
					$time, want.fault, want.paddr, resp_i.fault, resp_i.paddr);
				cmp_errors++;
			end
		end
	endtask

	task automatic compare_host();
		logic [31:0] want;
		if (host_exp_q.size() == 0) begin
			$display("Error at time %0t: host read answered with no read outstanding", $time);
			cmp_errors++;
		end else begin
			want = host_exp_q.pop_front();
			cmp_checks++;
			if (host_rdata_i !== want) begin
				$display("Mismatch at time %0t: host_rdata_o at %h expected %h actual %h",
					$time, host_i.addr, want, host_rdata_i);
				cmp_errors++;
			end
		end
	endtask

	// One line per finished test
	task automatic end_test(input string name);
		int checks;
		int errors;
		checks = cmp_checks - mark_checks;
		if (xlate_exp_q.size() != 0 || host_exp_q.size() != 0) begin
			$display("Error: %0d expected responses never arrived",
				xlate_exp_q.size() + host_exp_q.size());
			tb_errors++;
		end
		errors = error_count() - mark_errors;
		$display("Test %-26s %0d checks, %0d errors", name, checks, errors);
		mark_checks = cmp_checks;
		mark_errors = error_count();
	endtask

	task automatic report_totals();
		$display("Totals: %0d checks, %0d errors", cmp_checks, error_count());
	endtask

endmodule

//--- tb/tb_mmu.sv
module tb_mmu
	import mmu_pkg::*;
();

	localparam int TLB_ENTRIES = 16;
	localparam int MEM_WORDS   = 4096;
	localparam int TIMEOUT     = 200;
	localparam int N_SAVED     = 8;
	localparam logic [31:0] RAND_SEED = 32'hab4ce57a;

	logic              clk;
	logic              rst;
	logic              xlate_req;
	xlate_req_t        xlate_in;
	logic              xlate_ack;
	xlate_resp_t       resp;
	logic              flush;
	logic [TABLE_NUM_W-1:0] ptbr;
	logic              host_req;
	mem_req_t          host_in;
	logic              host_ack;
	logic [31:0]       host_rdata;

	// Reference copy of the table memory
	logic [31:0] model_mem [MEM_WORDS];
	// Addresses reused by the hit and flush tests
	xlate_req_t  saved [N_SAVED];
	// TLB slots already taken by saved addresses
	bit          idx_used [TLB_ENTRIES];

	tb_clock i_clock (.clk_o(clk), .rst_o(rst));

	mmu_top #(
		.TLB_ENTRIES(TLB_ENTRIES),
		.MEM_WORDS(MEM_WORDS)
	) i_mmu_top (
		.clk(clk), .rst(rst),
		.xlate_req_i(xlate_req), .xlate_i(xlate_in),
		.xlate_ack_o(xlate_ack), .resp_o(resp),
		.flush_i(flush), .ptbr_i(ptbr),
		.host_req_i(host_req), .host_i(host_in),
		.host_ack_o(host_ack), .host_rdata_o(host_rdata)
	);

	mmu_checker i_checker (
		.clk(clk), .rst(rst),
		.xlate_ack_i(xlate_ack), .resp_i(resp),
		.host_ack_i(host_ack), .host_i(host_in), .host_rdata_i(host_rdata)
	);

	// ==============================
	// Reference model
	// ==============================

	// Two-level walk over the model
	// Level 0 ok, 1 or 2 names the level holding the invalid entry
	function automatic xlate_resp_t model_xlate(input xlate_req_t x, output int level);
		pte_t        l1;
		pte_t        l0;
		xlate_resp_t r;
		r     = '0;
		level = 1;
		l1    = pte_t'(model_mem[{ptbr, x.vaddr.l1_idx}]);
		if (l1.v) begin
			level = 2;
			l0    = pte_t'(model_mem[{l1.ppn[TABLE_NUM_W-1:0], x.vaddr.l0_idx}]);
			if (l0.v) begin
				level   = 0;
				r.paddr = {l0.ppn, x.vaddr.offset};
			end
		end
		r.fault = (level != 0);
		return r;
	endfunction

	function automatic xlate_req_t random_req();
		xlate_req_t r;
		r.vaddr = vaddr_t'($urandom);
		r.asid  = asid_t'($urandom);
		return r;
	endfunction

	// ==============================
	// Stimulus tasks
	// ==============================

	// Drive point, just after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	// One four-phase host transfer
	task automatic host_access(input mem_op_e op, input logic [MEM_AW-1:0] addr,
		input logic [31:0] wdata);
		int n;
		host_in = '{op: op, addr: addr, wdata: wdata};
		if (op == MEM_WRITE)
			model_mem[addr] = wdata;
		else
			i_checker.expect_host(model_mem[addr]);
		host_req = 1'b1;
		n = 0;
		while (!host_ack && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (!host_ack)
			fail_timeout("host ack");
		host_req = 1'b0;
		n = 0;
		while (host_ack && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (host_ack)
			fail_timeout("host ack release");
	endtask

	// One four-phase lookup, latency in cycles from request to ack
	task automatic translate(input xlate_req_t x, output int latency);
		int n;
		int level;
		xlate_in = x;
		i_checker.expect_xlate(model_xlate(x, level));
		xlate_req = 1'b1;
		n = 0;
		while (!xlate_ack && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (!xlate_ack)
			fail_timeout("translation ack");
		latency = n;
		xlate_req = 1'b0;
		n = 0;
		while (xlate_ack && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (xlate_ack)
			fail_timeout("translation ack release");
	endtask

	// Random search for an address whose walk ends at the wanted level
	task automatic find_req(input int want, input bit unique_idx, output xlate_req_t x);
		int level;
		int tries;
		int idx;
		bit ok;
		tries = 0;
		ok    = 1'b0;
		idx   = 0;
		while (!ok && tries < 1000) begin
			x = random_req();
			void'(model_xlate(x, level));
			// TLB slot from the low vpn bits
			idx = int'({x.vaddr.l1_idx, x.vaddr.l0_idx}) % TLB_ENTRIES;
			ok  = (level == want) && !(unique_idx && idx_used[idx]);
			tries++;
		end
		if (ok) begin
			if (unique_idx)
				idx_used[idx] = 1'b1;
		end else begin
			$display("Error: no virtual address with walk result %0d found in the tables", want);
			i_checker.log_error();
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		xlate_req_t x;
		xlate_req_t x_par;
		pte_t       l1;
		pte_t       p;
		int         lat;
		int         lat_par;
		int         n;
		xlate_req  = 1'b0;
		xlate_in   = '0;
		flush      = 1'b0;
		host_req   = 1'b0;
		host_in    = '0;
		void'($urandom(RAND_SEED));
		ptbr = 2'($urandom);
		n = 0;
		while (rst && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (rst)
			fail_timeout("reset release");
		next_cycle();

		// Fill every table word, then spot-check
		for (int a = 0; a < MEM_WORDS; a++)
			host_access(MEM_WRITE, 12'(a), $urandom);
		for (int i = 0; i < 40; i++)
			host_access(MEM_READ, 12'($urandom), 32'd0);
		i_checker.end_test("table load and read-back");

		// Cold TLB, each lookup walks
		for (int i = 0; i < N_SAVED; i++) begin
			find_req(0, 1'b1, saved[i]);
			translate(saved[i], lat);
		end
		i_checker.end_test("miss walks");

		for (int i = 0; i < N_SAVED; i++) begin
			translate(saved[i], lat);
			if (lat != 2) begin
				$display("Mismatch at time %0t: hit latency expected 2 actual %0d", $time, lat);
				i_checker.log_error();
			end
		end
		// Other ASID, same page
		x = saved[0];
		x.asid = x.asid + 8'd1;
		translate(x, lat);
		if (lat <= 2) begin
			$display("Error: lookup with a changed ASID was answered as a hit");
			i_checker.log_error();
		end
		i_checker.end_test("hits");

		find_req(1, 1'b0, x);
		translate(x, lat);
		translate(x, lat);
		find_req(2, 1'b0, x);
		translate(x, lat);
		translate(x, lat);
		i_checker.end_test("faults");

		// New valid level-0 words under the cached pages
		for (int i = 0; i < N_SAVED; i++) begin
			l1  = pte_t'(model_mem[{ptbr, saved[i].vaddr.l1_idx}]);
			p   = pte_t'($urandom);
			p.v = 1'b1;
			host_access(MEM_WRITE, {l1.ppn[TABLE_NUM_W-1:0], saved[i].vaddr.l0_idx}, p);
		end
		flush = 1'b1;
		next_cycle();
		flush = 1'b0;
		for (int i = 0; i < N_SAVED; i++)
			translate(saved[i], lat);
		i_checker.end_test("flush");

		// Host reads racing translations on the arbiter
		fork
			begin
				for (int j = 0; j < 20; j++) begin
					x_par = random_req();
					translate(x_par, lat_par);
				end
			end
			begin
				for (int k = 0; k < 30; k++)
					host_access(MEM_READ, 12'($urandom), 32'd0);
			end
		join
		i_checker.end_test("contention");

		i_checker.report_totals();
		if (i_checker.error_count() == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- mmu_top.f
source/mmu_pkg.sv
source/ptable_mem.sv
source/mem_arbiter.sv
source/ptable_walker.sv
source/tlb.sv
source/mmu_top.sv
tb/tb_clock.sv
tb/mmu_checker.sv
tb/tb_mmu.sv

//--- Makefile
# Verilator simulation of the MMU testbench

VERILATOR ?= verilator
TOP       ?= tb_mmu
FILELIST  ?= mmu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
